//--- compile.f
source/pcmCodePkg.sv
source/pngenCfgPkg.sv
source/pngenRegs.sv
source/bitRateGen.sv
source/pnSequencer.sv
source/pcmEncoder.sv
source/pngenTop.sv
tests/pngenTb.sv

//--- run.sh
#!/bin/sh
# Builds the PCM pattern generator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module pngenTb -o pngenSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pngenSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1

//--- source/bitRateGen.sv
`default_nettype none

module bitRateGen import pngenCfgPkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     clkEn,
    input  wire pngenCfgT cfg,
    output strobeT        strobes
);

    logic [phaseWidth-1:0] phase;
    logic [phaseWidth:0]   phaseSum;
    logic                  pairToggle;
    logic                  advance;

    assign advance = clkEn && cfg.runEnable;

    // The carry out of the accumulator marks each half bit
    assign phaseSum = {1'b0, phase} + {1'b0, cfg.rateStep};
    assign strobes.halfStrobe = advance && phaseSum[phaseWidth];

    // Every second half bit closes a full bit
    assign strobes.bitStrobe = strobes.halfStrobe && pairToggle;

    always_ff @(posedge clk) begin
        if (reset || !cfg.runEnable) begin
            phase <= '0;
            pairToggle <= 1'b0;
        end else if (clkEn) begin
            phase <= phaseSum[phaseWidth-1:0];
            if (strobes.halfStrobe) begin
                pairToggle <= !pairToggle;
            end
        end
    end

    // Bit boundaries always coincide with a half-bit boundary
    bitOnHalfCheck: assert property (@(posedge clk) disable iff (reset)
        strobes.bitStrobe |-> strobes.halfStrobe);

endmodule

`default_nettype wire

//--- source/pcmCodePkg.sv
`default_nettype none

package pcmCodePkg;

    localparam int pcmCodeWidth = 4;

    // Delay modulation encodes the info bit from this many bit periods back
    localparam int dmDelay = 2;

    // Width of the zero and one run counters used by the MDM omission logic
    localparam int runCountWidth = 8;

    // Telemetry line codes, unlisted values fall back to plain NRZ
    typedef enum logic [pcmCodeWidth-1:0] {
        nrzL = 4'd0,
        nrzM = 4'd1,
        nrzS = 4'd2,
        bipL = 4'd3,
        bipM = 4'd4,
        bipS = 4'd5,
        dmM  = 4'd6,
        dmS  = 4'd7,
        mdmM = 4'd8,
        mdmS = 4'd9
    } pcmCodeT;

endpackage

`default_nettype wire

//--- source/pcmEncoder.sv
`default_nettype none

module pcmEncoder import pcmCodePkg::*, pngenCfgPkg::*; (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    clkEn,
    input  wire strobeT  strobes,
    input  wire pcmCodeT pcmCode,
    input  wire logic    pcmInvert,
    input  wire logic    nrzBit,
    output logic         pcmBit
);

    typedef enum logic {
        firstHalf,
        secondHalf
    } bitPhaseT;

    bitPhaseT                 bitPhase;
    logic                     halfTick;
    logic                     bitTick;
    logic                     spaceMode;
    logic                     modifyEnable;
    logic                     diffBit;
    logic                     diffNext;
    logic [dmDelay+1:0]       dmShift;
    logic                     dmBit;
    logic                     prevDmBit;
    logic [runCountWidth-1:0] zerosCount;
    logic [runCountWidth-1:0] onesCount;
    logic                     dmOmission;
    logic                     prevOmission;

    assign halfTick = clkEn && strobes.halfStrobe;
    assign bitTick = clkEn && strobes.bitStrobe;

    // Space variants work on inverted data
    assign spaceMode = pcmCode inside {nrzS, bipS, dmS, mdmS};
    assign modifyEnable = pcmCode inside {mdmM, mdmS};

    // Differential coder toggles on a one for mark and on a zero for space
    assign diffNext = diffBit ^ nrzBit ^ spaceMode;

    always_ff @(posedge clk) begin
        if (reset) begin
            diffBit <= 1'b0;
        end else if (bitTick) begin
            diffBit <= diffNext;
        end
    end

    // A lone half strobe is followed by the bit boundary
    always_ff @(posedge clk) begin
        if (reset) begin
            bitPhase <= firstHalf;
        end else if (halfTick) begin
            bitPhase <= bitTick ? firstHalf : secondHalf;
        end
    end

    assign dmBit = dmShift[dmDelay];
    assign prevDmBit = dmShift[dmDelay+1];

    // Omission detection looks at the newest bit in the pipeline, two bits ahead of
    // the one being encoded, so the flag lines up with the closing one
    always_ff @(posedge clk) begin
        if (reset) begin
            dmShift <= '0;
            zerosCount <= '0;
            onesCount <= '0;
            dmOmission <= 1'b0;
        end else if (bitTick) begin
            dmShift <= {dmShift[dmDelay:0], nrzBit ^ spaceMode};
            dmOmission <= 1'b0;
            if (dmShift[0]) begin
                onesCount <= onesCount + 1'b1;
            end else begin
                onesCount <= '0;
                // Even run of ones after an odd number of zeros
                if (onesCount != '0 && !onesCount[0] && zerosCount[0]) begin
                    dmOmission <= modifyEnable;
                end
                // A zero after a one starts a new zero run
                if (onesCount != '0) begin
                    zerosCount <= runCountWidth'(1);
                end else begin
                    zerosCount <= zerosCount + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcmBit <= 1'b0;
            prevOmission <= 1'b0;
        end else begin
            case (pcmCode)
                nrzL: begin
                    if (bitTick) begin
                        pcmBit <= pcmInvert ^ nrzBit;
                    end
                end
                nrzM, nrzS: begin
                    if (bitTick) begin
                        pcmBit <= pcmInvert ^ diffNext;
                    end
                end
                bipL: begin
                    if (halfTick) begin
                        pcmBit <= pcmInvert ^ nrzBit ^ (bitPhase == secondHalf);
                    end
                end
                bipM, bipS: begin
                    if (halfTick) begin
                        pcmBit <= pcmInvert ^ diffNext ^ (bitPhase == secondHalf);
                    end
                end
                dmM, dmS, mdmM, mdmS: begin
                    if (halfTick) begin
                        if (bitPhase == secondHalf) begin
                            // Boundary transition between two zeros
                            if (!dmBit && !prevDmBit) begin
                                pcmBit <= !pcmBit;
                            end
                            prevOmission <= dmOmission;
                        end else if (prevDmBit && !prevOmission) begin
                            // Mid-bit transition for a one unless omitted
                            pcmBit <= !pcmBit;
                        end
                    end
                end
                default: begin
                    if (bitTick) begin
                        pcmBit <= nrzBit;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/pnSequencer.sv
`default_nettype none

module pnSequencer import pngenCfgPkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     clkEn,
    input  wire pngenCfgT cfg,
    input  wire strobeT   strobes,
    output logic          nrzBit
);

    logic [seedWidth-1:0] lfsr;
    logic [seedWidth-1:0] seedMasked;
    logic [seedWidth-1:0] activeState;
    pnPolyT               polyActive;
    logic                 feedback;

    // Bits of the register that belong to the selected polynomial
    function automatic logic [seedWidth-1:0] maskOf(input pnPolyT poly);
        case (poly)
            pn9:     maskOf = {seedWidth{1'b1}} >> (seedWidth - 9);
            pn11:    maskOf = {seedWidth{1'b1}} >> (seedWidth - 11);
            pn15:    maskOf = {seedWidth{1'b1}} >> (seedWidth - 15);
            default: maskOf = {seedWidth{1'b1}};
        endcase
    endfunction

    // Tap n sits at lfsr[n-1], the newest bit enters at lfsr[0]
    always_comb begin
        case (polyActive)
            pn9:     feedback = lfsr[8] ^ lfsr[4];
            pn11:    feedback = lfsr[10] ^ lfsr[8];
            pn15:    feedback = lfsr[14] ^ lfsr[13];
            default: feedback = lfsr[22] ^ lfsr[17];
        endcase
    end

    assign seedMasked = cfg.seed & maskOf(cfg.pnPoly);
    assign activeState = lfsr & maskOf(polyActive);

    // The polynomial is taken over together with the seed
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= '1;
            polyActive <= pn23;
            nrzBit <= 1'b0;
        end else if (cfg.seedLoad) begin
            polyActive <= cfg.pnPoly;
            lfsr <= (seedMasked == '0) ? maskOf(cfg.pnPoly) : seedMasked;
        end else if (clkEn && strobes.bitStrobe) begin
            lfsr <= {lfsr[seedWidth-2:0], feedback};
            nrzBit <= feedback;
        end
    end

    activeStateCheck: assert property (@(posedge clk) disable iff (reset)
        activeState != '0);

endmodule

`default_nettype wire

//--- source/pngenCfgPkg.sv
`default_nettype none

package pngenCfgPkg;

    import pcmCodePkg::*;

    localparam int phaseWidth = 16;
    localparam int seedWidth = 23;

    typedef enum logic [1:0] {
        pn9  = 2'd0,
        pn11 = 2'd1,
        pn15 = 2'd2,
        pn23 = 2'd3
    } pnPolyT;

    // Control holds enable in bit 0, invert in bit 1, code in 7:4 and polynomial in 9:8
    typedef enum logic [1:0] {
        regControl = 2'd0,
        regRate    = 2'd1,
        regSeed    = 2'd2
    } regAddrT;

    typedef struct packed {
        logic                  runEnable;
        logic                  pcmInvert;
        pcmCodeT               pcmCode;
        pnPolyT                pnPoly;
        logic [phaseWidth-1:0] rateStep;
        logic [seedWidth-1:0]  seed;
        logic                  seedLoad;
    } pngenCfgT;

    typedef struct packed {
        logic halfStrobe;
        logic bitStrobe;
    } strobeT;

endpackage

`default_nettype wire

//--- source/pngenRegs.sv
`default_nettype none

module pngenRegs import pcmCodePkg::*, pngenCfgPkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        regWrite,
    input  wire regAddrT     regAddr,
    input  wire logic [31:0] regData,
    output pngenCfgT         cfg
);

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.runEnable <= 1'b0;
            cfg.pcmInvert <= 1'b0;
            cfg.pcmCode <= nrzL;
            cfg.pnPoly <= pn9;
            cfg.rateStep <= '0;
            cfg.seed <= '1;
            cfg.seedLoad <= 1'b0;
        end else begin
            // The seed load is a single cycle pulse following the write
            cfg.seedLoad <= 1'b0;
            if (regWrite) begin
                case (regAddr)
                    regControl: begin
                        cfg.runEnable <= regData[0];
                        cfg.pcmInvert <= regData[1];
                        cfg.pcmCode <= pcmCodeT'(regData[4 +: pcmCodeWidth]);
                        cfg.pnPoly <= pnPolyT'(regData[9:8]);
                    end
                    regRate: begin
                        cfg.rateStep <= regData[phaseWidth-1:0];
                    end
                    regSeed: begin
                        cfg.seed <= regData[seedWidth-1:0];
                        cfg.seedLoad <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // An all-zero seed would stall the LFSR
    seedLoadCheck: assert property (@(posedge clk) disable iff (reset)
        cfg.seedLoad |-> cfg.seed != '0);

endmodule

`default_nettype wire

//--- source/pngenTop.sv
`default_nettype none

module pngenTop import pngenCfgPkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        clkEn,
    input  wire logic        regWrite,
    input  wire regAddrT     regAddr,
    input  wire logic [31:0] regData,
    output logic             pcmBit,
    output logic             nrzBit,
    output strobeT           strobes
);

    pngenCfgT cfg;

    pngenRegs pngenRegs_i (
        .clk      (clk),
        .reset    (reset),
        .regWrite (regWrite),
        .regAddr  (regAddr),
        .regData  (regData),
        .cfg      (cfg)
    );

    bitRateGen bitRateGen_i (
        .clk     (clk),
        .reset   (reset),
        .clkEn   (clkEn),
        .cfg     (cfg),
        .strobes (strobes)
    );

    pnSequencer pnSequencer_i (
        .clk     (clk),
        .reset   (reset),
        .clkEn   (clkEn),
        .cfg     (cfg),
        .strobes (strobes),
        .nrzBit  (nrzBit)
    );

    // The encoder sees the PN stream as it leaves the sequencer
    pcmEncoder pcmEncoder_i (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (clkEn),
        .strobes   (strobes),
        .pcmCode   (cfg.pcmCode),
        .pcmInvert (cfg.pcmInvert),
        .nrzBit    (nrzBit),
        .pcmBit    (pcmBit)
    );

endmodule

`default_nettype wire

//--- tests/pngenTb.sv
`default_nettype none

module pngenTb import pcmCodePkg::*, pngenCfgPkg::*; ();

    localparam int strobeTimeout = 400;
    localparam int rowCount = 11;

    typedef struct packed {
        pcmCodeT   code;
        logic      invert;
        pnPolyT    poly;
        logic [15:0] rate;
        int        bits;
    } rowT;

    logic        clk;
    logic        reset;
    logic        clkEn;
    logic        regWrite;
    regAddrT     regAddr;
    logic [31:0] regData;
    logic        pcmBit;
    logic        nrzBit;
    strobeT      strobes;

    rowT                  rows [0:rowCount-1];
    logic [15:0]          rngState;
    logic [seedWidth-1:0] pnState;
    int                   errorCount;
    int                   checkCount;
    int                   testCount;

    pngenTop pngenTop_i (
        .clk      (clk),
        .reset    (reset),
        .clkEn    (clkEn),
        .regWrite (regWrite),
        .regAddr  (regAddr),
        .regData  (regData),
        .pcmBit   (pcmBit),
        .nrzBit   (nrzBit),
        .strobes  (strobes)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checkCount++;
        assert (expected === actual) else begin
            $display("MISMATCH %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testCount++;
        $display("Test %0d %s: %0d errors", testCount, name, errorCount - startErrors);
    endtask

    // Galois LFSR, one step per random bit taken
    task automatic takeRandom(input int n, output logic [31:0] value);
        logic lsb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lsb = rngState[0];
            value = {value[30:0], lsb};
            rngState = rngState >> 1;
            if (lsb) begin
                rngState = rngState ^ 16'hB400;
            end
        end
    endtask

    // Fibonacci model, the newest bit enters at the bottom and is the output
    task automatic pnStep(input pnPolyT poly, output logic fb);
        case (poly)
            pn9:     fb = pnState[8] ^ pnState[4];
            pn11:    fb = pnState[10] ^ pnState[8];
            pn15:    fb = pnState[14] ^ pnState[13];
            default: fb = pnState[22] ^ pnState[17];
        endcase
        pnState = {pnState[seedWidth-2:0], fb};
    endtask

    task automatic writeReg(input regAddrT addr, input logic [31:0] data);
        regWrite = 1'b1;
        regAddr = addr;
        regData = data;
        @(negedge clk);
        regWrite = 1'b0;
        regData = '0;
    endtask

    // Returns one cycle after a half strobe, with the values seen at the strobe
    task automatic waitHalf(output logic isBit, output logic nrzPre, output logic pcmPre);
        int waited;
        waited = 0;
        while (!strobes.halfStrobe && waited < strobeTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (!strobes.halfStrobe) begin
            $display("Timeout: no halfStrobe within %0d cycles", strobeTimeout);
            $display("Simulation failed");
            $finish;
        end else begin
            isBit = strobes.bitStrobe;
            nrzPre = nrzBit;
            pcmPre = pcmBit;
            @(negedge clk);
        end
    endtask

    task automatic checkResetState();
        int startErrors;
        startErrors = errorCount;
        repeat (100) begin
            checkBit("pcmBit", 1'b0, pcmBit);
            checkBit("nrzBit", 1'b0, nrzBit);
            checkBit("halfStrobe", 1'b0, strobes.halfStrobe);
            checkBit("bitStrobe", 1'b0, strobes.bitStrobe);
            @(negedge clk);
        end
        reportTest("reset state", startErrors);
    endtask

    task automatic runRow(input int idx);
        rowT         r;
        logic [31:0] seedBits;
        logic [9:0]  control;
        logic        space;
        logic        modified;
        logic        isBit;
        logic        nrzPre;
        logic        pcmPre;
        logic        expBit;
        logic        toggled;
        logic        level;
        logic        haveLevel;
        logic [7:0]  dHist;
        logic [7:0]  omitHist;
        logic [7:0]  unsureHist;
        logic        zerosValid;
        int          oneRun;
        int          zeroRun;
        int          bitCount;
        int          startErrors;
        r = rows[idx];
        startErrors = errorCount;
        space = r.code inside {nrzS, bipS, dmS, mdmS};
        modified = r.code inside {mdmM, mdmS};
        control = {r.poly, r.code, 2'b00, r.invert, 1'b0};
        takeRandom(seedWidth, seedBits);
        seedBits[0] = 1'b1;
        writeReg(regControl, {22'd0, control});
        writeReg(regRate, {16'd0, r.rate});
        writeReg(regSeed, seedBits);
        writeReg(regControl, {22'd0, control | 10'd1});
        pnState = seedBits[seedWidth-1:0];
        case (r.poly)
            pn9:     pnState = pnState & 23'h0001FF;
            pn11:    pnState = pnState & 23'h0007FF;
            pn15:    pnState = pnState & 23'h007FFF;
            default: pnState = pnState;
        endcase
        haveLevel = 1'b0;
        level = 1'b0;
        dHist = '0;
        omitHist = '0;
        unsureHist = '0;
        zerosValid = 1'b0;
        oneRun = 0;
        zeroRun = 0;
        bitCount = 0;
        while (bitCount < r.bits) begin
            waitHalf(isBit, nrzPre, pcmPre);
            toggled = pcmBit != pcmPre;
            if (isBit) begin
                bitCount++;
                pnStep(r.poly, expBit);
                checkBit("nrzBit", expBit, nrzBit);
                dHist = {dHist[6:0], nrzPre ^ space};
                omitHist = {omitHist[6:0], 1'b0};
                unsureHist = {unsureHist[6:0], 1'b0};
                if (dHist[0]) begin
                    oneRun++;
                end else begin
                    // A zero closes the run of ones before it, the last one sits at index 1
                    if (oneRun != 0) begin
                        omitHist[1] = modified && zerosValid && oneRun % 2 == 0
                                      && zeroRun % 2 == 1;
                        unsureHist[1] = modified && !zerosValid;
                        zeroRun = 1;
                        zerosValid = 1'b1;
                    end else begin
                        zeroRun++;
                    end
                    oneRun = 0;
                end
            end
            case (r.code)
                nrzL: begin
                    if (isBit) checkBit("pcmBit", r.invert ^ nrzPre, pcmBit);
                end
                nrzM, nrzS: begin
                    if (isBit && haveLevel) begin
                        level = level ^ nrzPre ^ space;
                        checkBit("pcmBit", r.invert ^ level, pcmBit);
                    end else if (isBit) begin
                        level = pcmBit ^ r.invert;
                        haveLevel = 1'b1;
                    end
                end
                bipL: begin
                    checkBit("pcmBit", r.invert ^ nrzPre ^ isBit, pcmBit);
                end
                bipM, bipS: begin
                    // The first half carries the differential level, the second its complement
                    if (!isBit && haveLevel) begin
                        level = level ^ nrzPre ^ space;
                        checkBit("pcmBit", r.invert ^ level, pcmBit);
                    end else if (!isBit) begin
                        level = pcmBit ^ r.invert;
                        haveLevel = 1'b1;
                    end else if (haveLevel) begin
                        checkBit("pcmBit", !(r.invert ^ level), pcmBit);
                    end
                end
                default: begin
                    // Pipeline history from the previous row is flushed after six bits
                    if (bitCount >= 6 && isBit) begin
                        checkBit("pcmBit boundary transition", !dHist[3] && !dHist[4], toggled);
                    end else if (bitCount >= 6 && !unsureHist[3]) begin
                        checkBit("pcmBit mid-bit transition", dHist[3] && !omitHist[3],
                                 toggled);
                    end
                end
            endcase
        end
        reportTest($sformatf("row %0d %s", idx, r.code.name()), startErrors);
    endtask

    task automatic checkRate(input logic [15:0] step);
        int count;
        int expected;
        int startErrors;
        startErrors = errorCount;
        writeReg(regControl, 32'd0);
        writeReg(regRate, {16'd0, step});
        writeReg(regControl, 32'd1);
        count = 0;
        repeat (4096) begin
            if (strobes.halfStrobe) count++;
            @(negedge clk);
        end
        writeReg(regControl, 32'd0);
        expected = (4096 * int'(step)) >> 16;
        checkCount++;
        assert (count >= expected - 1 && count <= expected + 1) else begin
            $display("MISMATCH halfStrobe count expected 0x%h actual 0x%h", expected, count);
            errorCount++;
        end
        reportTest($sformatf("rate 0x%h", step), startErrors);
    endtask

    initial begin
        reset = 1'b1;
        clkEn = 1'b0;
        regWrite = 1'b0;
        regAddr = regControl;
        regData = '0;
        rngState = 16'd59799;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        rows[0] = '{nrzL, 1'b0, pn9, 16'h2000, 40};
        rows[1] = '{nrzL, 1'b1, pn11, 16'h1800, 40};
        rows[2] = '{nrzM, 1'b0, pn15, 16'h2000, 40};
        rows[3] = '{nrzS, 1'b1, pn23, 16'h1000, 40};
        rows[4] = '{bipL, 1'b0, pn9, 16'h2000, 40};
        rows[5] = '{bipM, 1'b1, pn11, 16'h1C00, 40};
        rows[6] = '{bipS, 1'b0, pn15, 16'h2000, 40};
        rows[7] = '{dmM, 1'b0, pn23, 16'h2000, 60};
        rows[8] = '{dmS, 1'b1, pn9, 16'h1800, 60};
        rows[9] = '{mdmM, 1'b0, pn11, 16'h2000, 80};
        rows[10] = '{mdmS, 1'b0, pn15, 16'h2000, 80};
        repeat (16) @(negedge clk);
        reset = 1'b0;
        clkEn = 1'b1;
        checkResetState();
        for (int i = 0; i < rowCount; i++) begin
            runRow(i);
        end
        checkRate(16'h1234);
        checkRate(16'h0F0F);
        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
